//--- src/disp_cfg.svh
// Dispatch stage sizes
// Shared by the package and every dispatcher block
`ifndef DISP_CFG_SVH
`define DISP_CFG_SVH

// Instructions in flight, one tag each
`define DISP_NUM_TAGS 8

// Parked instructions, kept below the tag count
`define DISP_WB_DEPTH 4

// Register index width, 32 architectural registers
`define DISP_REG_IDX_W 5

// Program counter width
`define DISP_PC_W 16

// One mask bit per thread of the warp
`define DISP_WARP_W 8

// Source operands per instruction
`define DISP_NUM_OPS 2

`endif

//--- src/disp_pkg.sv
// Dispatch stage types
// Tag, register index, pc, thread mask and wait-buffer entry
`include "disp_cfg.svh"

package disp_pkg;

    // Derived sizes
    localparam int unsigned TAG_W    = $clog2(`DISP_NUM_TAGS);
    localparam int unsigned NUM_REGS = 2 ** `DISP_REG_IDX_W;
    localparam int unsigned NUM_OPS  = `DISP_NUM_OPS;

    typedef logic [TAG_W-1:0]           tag_t;
    typedef logic [`DISP_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`DISP_PC_W-1:0]      pc_t;
    typedef logic [`DISP_WARP_W-1:0]    act_mask_t;

    // One parked instruction
    // op_tag is only meaningful while the matching op_ready bit is low
    typedef struct packed {
        logic                 valid;
        pc_t                  pc;
        act_mask_t            mask;
        tag_t                 tag;
        reg_idx_t             dst;
        tag_t [NUM_OPS-1:0]   op_tag;
        logic [NUM_OPS-1:0]   op_ready;
    } wb_entry_t;

endpackage : disp_pkg

//--- src/tag_queue.sv
// Free tag queue
// Circular FIFO holding every unused tag, popped on dispatch, refilled on completion
`include "disp_cfg.svh"

module tag_queue (
    input  logic           clk_i,
    input  logic           arst_n_i,
    // Dispatch takes the head tag
    input  logic           pop_i,
    // Completion returns a tag
    input  logic           push_i,
    input  disp_pkg::tag_t push_tag_i,
    output logic           avail_o,
    output disp_pkg::tag_t tag_o
);

    import disp_pkg::*;

    localparam int unsigned DEPTH = `DISP_NUM_TAGS;

    typedef logic [TAG_W:0] cnt_t;

    // Storage, pointers and fill level
    tag_t mem_q [DEPTH];
    tag_t rd_ptr_q;
    tag_t wr_ptr_q;
    cnt_t count_q;
    logic do_pop;

    // Wrap at the last slot
    function automatic tag_t next_ptr(tag_t ptr);
        return (ptr == tag_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Never pop an empty queue
    assign do_pop = pop_i && avail_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // Every tag starts free, in ascending order
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= tag_t'(i);
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= cnt_t'(DEPTH);
        end else begin
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (push_i) begin
                mem_q[wr_ptr_q] <= push_tag_i;
                wr_ptr_q        <= next_ptr(wr_ptr_q);
            end
            // Push with pop keeps the level
            if (do_pop && !push_i) begin
                count_q <= count_q - 1'b1;
            end else if (push_i && !do_pop) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign avail_o = (count_q != '0);
    assign tag_o   = mem_q[rd_ptr_q];

endmodule : tag_queue

//--- src/reg_table.sv
// Register dependency table
// Busy flag and producer tag per register, looked up for each source on dispatch
`include "disp_cfg.svh"

module reg_table (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // New instruction and its tag
    input  logic                     insert_i,
    input  disp_pkg::tag_t           tag_i,
    input  disp_pkg::reg_idx_t       dst_i,
    input  disp_pkg::reg_idx_t       src0_i,
    input  disp_pkg::reg_idx_t       src1_i,
    // Completion strobe
    input  logic                     cmpl_valid_i,
    input  disp_pkg::tag_t           cmpl_tag_i,
    // Lookup result per source
    output logic [`DISP_NUM_OPS-1:0] op_ready_o,
    output disp_pkg::tag_t           op_tag0_o,
    output disp_pkg::tag_t           op_tag1_o
);

    import disp_pkg::*;

    logic [NUM_REGS-1:0] busy_q;
    tag_t                owner_q [NUM_REGS];

    // ########################################################################
    // Source lookup
    // ########################################################################

    // Producer tag, the wait buffer ignores it when the source is ready
    assign op_tag0_o = owner_q[src0_i];
    assign op_tag1_o = owner_q[src1_i];

    // Ready when idle, or when its producer retires in this very cycle
    assign op_ready_o[0] = !busy_q[src0_i]
                           || (cmpl_valid_i && owner_q[src0_i] == cmpl_tag_i);
    assign op_ready_o[1] = !busy_q[src1_i]
                           || (cmpl_valid_i && owner_q[src1_i] == cmpl_tag_i);

    // ########################################################################
    // Table update
    // ########################################################################

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= '0;
        end else begin
            // Only the current owner may clear its register
            for (int r = 0; r < NUM_REGS; r++) begin
                if (cmpl_valid_i && busy_q[r] && owner_q[r] == cmpl_tag_i) begin
                    busy_q[r] <= 1'b0;
                end
            end
            // Set after the clear, so a new writer beats a retiring one
            if (insert_i) begin
                busy_q[dst_i] <= 1'b1;
            end
        end
    end

    // Producer tags
    always_ff @(posedge clk_i) begin
        if (insert_i) begin
            owner_q[dst_i] <= tag_i;
        end
    end

endmodule : reg_table

//--- src/wait_buffer.sv
// Wait buffer
// Parks dispatched instructions until both operands are ready, then issues them
`include "disp_cfg.svh"

module wait_buffer (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // Insertion from the dispatcher
    input  logic                     insert_i,
    input  disp_pkg::pc_t            pc_i,
    input  disp_pkg::act_mask_t      mask_i,
    input  disp_pkg::tag_t           tag_i,
    input  disp_pkg::reg_idx_t       dst_i,
    input  disp_pkg::tag_t           op_tag0_i,
    input  disp_pkg::tag_t           op_tag1_i,
    input  logic [`DISP_NUM_OPS-1:0] op_ready_i,
    output logic                     space_o,
    // Completion strobe
    input  logic                     cmpl_valid_i,
    input  disp_pkg::tag_t           cmpl_tag_i,
    // Four-phase issue port
    output logic                     iss_req_o,
    input  logic                     iss_ack_i,
    output disp_pkg::pc_t            iss_pc_o,
    output disp_pkg::act_mask_t      iss_mask_o,
    output disp_pkg::tag_t           iss_tag_o,
    output disp_pkg::reg_idx_t       iss_dst_o
);

    import disp_pkg::*;

    localparam int unsigned DEPTH = `DISP_WB_DEPTH;
    localparam int unsigned IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef enum logic {
        ISS_IDLE,
        ISS_REQ
    } iss_state_e;

    wb_entry_t        entry_q [DEPTH];
    wb_entry_t        new_entry;
    iss_state_e       state_q;
    logic [IDX_W-1:0] iss_idx_q;
    logic             iss_start;

    // Slot search results
    logic             free_found;
    logic [IDX_W-1:0] free_idx;
    logic             rdy_found;
    logic [IDX_W-1:0] rdy_idx;

    // ########################################################################
    // Slot search
    // ########################################################################

    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        rdy_found  = 1'b0;
        rdy_idx    = '0;
        // Scan downwards, lowest index wins
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!entry_q[i].valid) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
            if (entry_q[i].valid && (&entry_q[i].op_ready)) begin
                rdy_found = 1'b1;
                rdy_idx   = IDX_W'(i);
            end
        end
    end

    assign space_o = free_found;

    // Incoming instruction as stored
    always_comb begin
        new_entry          = '0;
        new_entry.valid    = 1'b1;
        new_entry.pc       = pc_i;
        new_entry.mask     = mask_i;
        new_entry.tag      = tag_i;
        new_entry.dst      = dst_i;
        new_entry.op_tag   = {op_tag1_i, op_tag0_i};
        new_entry.op_ready = op_ready_i;
    end

    // ########################################################################
    // Entry storage
    // ########################################################################

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                entry_q[i].valid <= 1'b0;
            end
        end else begin
            // Wake every operand waiting on the finished tag
            for (int i = 0; i < DEPTH; i++) begin
                for (int o = 0; o < NUM_OPS; o++) begin
                    if (cmpl_valid_i && entry_q[i].valid && !entry_q[i].op_ready[o]
                        && entry_q[i].op_tag[o] == cmpl_tag_i) begin
                        entry_q[i].op_ready[o] <= 1'b1;
                    end
                end
            end
            // Acknowledged issue frees its slot
            if (state_q == ISS_REQ && iss_ack_i) begin
                entry_q[iss_idx_q].valid <= 1'b0;
            end
            // Never the issuing slot, that one is still valid
            if (insert_i && free_found) begin
                entry_q[free_idx] <= new_entry;
            end
        end
    end

    // ########################################################################
    // Issue FSM
    // ########################################################################

    // Start only once the previous acknowledge has dropped
    assign iss_start = (state_q == ISS_IDLE) && rdy_found && !iss_ack_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ISS_IDLE;
            iss_idx_q <= '0;
        end else begin
            case (state_q)
                ISS_IDLE: begin
                    if (iss_start) begin
                        state_q   <= ISS_REQ;
                        iss_idx_q <= rdy_idx;
                    end
                end
                ISS_REQ: begin
                    // Request falls on the acknowledge edge
                    if (iss_ack_i) begin
                        state_q <= ISS_IDLE;
                    end
                end
                default: state_q <= ISS_IDLE;
            endcase
        end
    end

    // Payload held stable while the request is up
    always_ff @(posedge clk_i) begin
        if (iss_start) begin
            iss_pc_o   <= entry_q[rdy_idx].pc;
            iss_mask_o <= entry_q[rdy_idx].mask;
            iss_tag_o  <= entry_q[rdy_idx].tag;
            iss_dst_o  <= entry_q[rdy_idx].dst;
        end
    end

    assign iss_req_o = (state_q == ISS_REQ);

endmodule : wait_buffer

//--- src/dispatcher.sv
// SIMT dispatch stage, top level
// Tags each decoded instruction, tracks register dependencies and issues out of order
`include "disp_cfg.svh"

module dispatcher (
    input  logic                clk_i,
    input  logic                arst_n_i,
    // Four-phase decode port
    input  logic                dec_req_i,
    output logic                dec_ack_o,
    input  disp_pkg::pc_t       dec_pc_i,
    input  disp_pkg::act_mask_t dec_mask_i,
    input  disp_pkg::reg_idx_t  dec_dst_i,
    input  disp_pkg::reg_idx_t  dec_src0_i,
    input  disp_pkg::reg_idx_t  dec_src1_i,
    // Four-phase issue port
    output logic                iss_req_o,
    input  logic                iss_ack_i,
    output disp_pkg::pc_t       iss_pc_o,
    output disp_pkg::act_mask_t iss_mask_o,
    output disp_pkg::tag_t      iss_tag_o,
    output disp_pkg::reg_idx_t  iss_dst_o,
    // Completion strobe from the execution unit
    input  logic                cmpl_valid_i,
    input  disp_pkg::tag_t      cmpl_tag_i
);

    import disp_pkg::*;

    // Tag queue
    logic               tag_avail;
    tag_t               free_tag;
    // Register table lookup
    logic [NUM_OPS-1:0] op_ready;
    tag_t               op_tag0;
    tag_t               op_tag1;
    // Wait buffer
    logic               wb_space;
    // Decode acceptance
    logic               insert;
    logic               dec_ack_q;

    // ########################################################################
    // Decode handshake
    // ########################################################################

    // Accept a fresh request when a tag and a slot are both free
    assign insert = dec_req_i && !dec_ack_q && tag_avail && wb_space;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_ack_q <= 1'b0;
        end else begin
            // Held until the request falls
            dec_ack_q <= insert || (dec_ack_q && dec_req_i);
        end
    end

    assign dec_ack_o = dec_ack_q;

    // ########################################################################
    // Sub-blocks
    // ########################################################################

    tag_queue u_tag_queue (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .pop_i      (insert),
        .push_i     (cmpl_valid_i),
        .push_tag_i (cmpl_tag_i),
        .avail_o    (tag_avail),
        .tag_o      (free_tag)
    );

    reg_table u_reg_table (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .insert_i     (insert),
        .tag_i        (free_tag),
        .dst_i        (dec_dst_i),
        .src0_i       (dec_src0_i),
        .src1_i       (dec_src1_i),
        .cmpl_valid_i (cmpl_valid_i),
        .cmpl_tag_i   (cmpl_tag_i),
        .op_ready_o   (op_ready),
        .op_tag0_o    (op_tag0),
        .op_tag1_o    (op_tag1)
    );

    wait_buffer u_wait_buffer (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .insert_i     (insert),
        .pc_i         (dec_pc_i),
        .mask_i       (dec_mask_i),
        .tag_i        (free_tag),
        .dst_i        (dec_dst_i),
        .op_tag0_i    (op_tag0),
        .op_tag1_i    (op_tag1),
        .op_ready_i   (op_ready),
        .space_o      (wb_space),
        .cmpl_valid_i (cmpl_valid_i),
        .cmpl_tag_i   (cmpl_tag_i),
        .iss_req_o    (iss_req_o),
        .iss_ack_i    (iss_ack_i),
        .iss_pc_o     (iss_pc_o),
        .iss_mask_o   (iss_mask_o),
        .iss_tag_o    (iss_tag_o),
        .iss_dst_o    (iss_dst_o)
    );

    // A full buffer has to leave tags for the instructions already issued
    if (`DISP_WB_DEPTH >= `DISP_NUM_TAGS) begin : gen_depth_check
        $fatal(1, "DISP_WB_DEPTH must be smaller than DISP_NUM_TAGS");
    end

endmodule : dispatcher

//--- verif/dispatcher_props.sv
// Handshake and tag checks for the dispatch stage
// Bound into the dispatcher top level
module dispatcher_props (
    input logic                clk_i,
    input logic                arst_n_i,
    input logic                dec_req_i,
    input logic                dec_ack_o,
    input disp_pkg::pc_t       dec_pc_i,
    input disp_pkg::act_mask_t dec_mask_i,
    input disp_pkg::reg_idx_t  dec_dst_i,
    input disp_pkg::reg_idx_t  dec_src0_i,
    input disp_pkg::reg_idx_t  dec_src1_i,
    input logic                iss_req_o,
    input logic                iss_ack_i,
    input disp_pkg::pc_t       iss_pc_o,
    input disp_pkg::act_mask_t iss_mask_o,
    input disp_pkg::tag_t      iss_tag_o,
    input disp_pkg::reg_idx_t  iss_dst_o,
    input logic                cmpl_valid_i,
    // Internal dispatcher net
    input logic                tag_avail_i
);

    // ########################################################################
    // Decode port
    // ########################################################################

    a_dec_ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(dec_ack_o) |-> $past(dec_req_i))
        else $error("decode acknowledge raised without a request");

    // Decoder only restarts once the acknowledge is gone
    a_dec_req_after_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(dec_req_i) |-> !dec_ack_o)
        else $error("decode request raised while the acknowledge is high");

    // Request and payload hold until accepted
    a_dec_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (dec_req_i && !dec_ack_o) |=> (dec_ack_o || (dec_req_i
        && $stable({dec_pc_i, dec_mask_i, dec_dst_i, dec_src0_i, dec_src1_i}))))
        else $error("decode request or payload changed before the acknowledge");

    // ########################################################################
    // Issue port
    // ########################################################################

    a_iss_ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(iss_ack_i) |-> iss_req_o)
        else $error("issue acknowledge raised without a request");

    a_iss_req_after_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(iss_req_o) |-> !$past(iss_ack_i))
        else $error("issue request raised while the acknowledge is high");

    a_iss_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (iss_req_o && !iss_ack_i) |=> (iss_req_o
        && $stable({iss_pc_o, iss_mask_o, iss_tag_o, iss_dst_o})))
        else $error("issue request or payload changed before the acknowledge");

    // ########################################################################
    // Tag queue
    // ########################################################################

    // A returned tag can be handed out from the next cycle on
    a_tag_return: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cmpl_valid_i |=> tag_avail_i)
        else $error("no free tag in the cycle after a completion");

endmodule : dispatcher_props

bind dispatcher dispatcher_props u_props (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .dec_req_i    (dec_req_i),
    .dec_ack_o    (dec_ack_o),
    .dec_pc_i     (dec_pc_i),
    .dec_mask_i   (dec_mask_i),
    .dec_dst_i    (dec_dst_i),
    .dec_src0_i   (dec_src0_i),
    .dec_src1_i   (dec_src1_i),
    .iss_req_o    (iss_req_o),
    .iss_ack_i    (iss_ack_i),
    .iss_pc_o     (iss_pc_o),
    .iss_mask_o   (iss_mask_o),
    .iss_tag_o    (iss_tag_o),
    .iss_dst_o    (iss_dst_o),
    .cmpl_valid_i (cmpl_valid_i),
    .tag_avail_i  (tag_avail)
);

//--- verif/dispatcher_tb.sv
// Testbench for the SIMT dispatch stage
// Random decode traffic checked against a dependency model and an execution-unit model
`include "disp_cfg.svh"

module dispatcher_tb;

    import disp_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DLY   = 10;
    localparam int RST_CYCLES  = 8;
    localparam int N_INSTR     = 300;
    localparam int NUM_TAGS    = `DISP_NUM_TAGS;
    localparam int WB_DEPTH    = `DISP_WB_DEPTH;
    // Completions withheld up to this cycle to force back-pressure
    localparam int HOLD_CYCLES = 100;

    logic      clk_i;
    logic      arst_n_i;
    logic      dec_req_i;
    logic      dec_ack_o;
    pc_t       dec_pc_i;
    act_mask_t dec_mask_i;
    reg_idx_t  dec_dst_i;
    reg_idx_t  dec_src0_i;
    reg_idx_t  dec_src1_i;
    logic      iss_req_o;
    logic      iss_ack_i;
    pc_t       iss_pc_o;
    act_mask_t iss_mask_o;
    tag_t      iss_tag_o;
    reg_idx_t  iss_dst_o;
    logic      cmpl_valid_i;
    tag_t      cmpl_tag_i;

    logic [31:0] lfsr_q;
    int          errors;
    int          cycle;
    int          accepted;
    int          acked;
    int          completed;
    bit          hold_cmpl;
    bit          ack_prev;
    int          gap;

    // Per instruction, indexed by acceptance order
    pc_t       acc_pc   [N_INSTR];
    act_mask_t acc_mask [N_INSTR];
    reg_idx_t  acc_dst  [N_INSTR];
    int        acc_dep0 [N_INSTR];
    int        acc_dep1 [N_INSTR];
    bit        is_issued[N_INSTR];
    bit        is_done  [N_INSTR];

    // Shadow state, -1 marks a free tag or an idle register
    int tag_owner[NUM_TAGS];
    int reg_owner[NUM_REGS];
    int free_tags[$];

    // Execution unit, issued tags waiting to complete
    int pend_tag [$];
    int pend_wait[$];
    bit iss_seen;
    int iss_tag_q;
    int ack_wait;

    dispatcher u_dut (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .dec_req_i    (dec_req_i),
        .dec_ack_o    (dec_ack_o),
        .dec_pc_i     (dec_pc_i),
        .dec_mask_i   (dec_mask_i),
        .dec_dst_i    (dec_dst_i),
        .dec_src0_i   (dec_src0_i),
        .dec_src1_i   (dec_src1_i),
        .iss_req_o    (iss_req_o),
        .iss_ack_i    (iss_ack_i),
        .iss_pc_o     (iss_pc_o),
        .iss_mask_o   (iss_mask_o),
        .iss_tag_o    (iss_tag_o),
        .iss_dst_o    (iss_dst_o),
        .cmpl_valid_i (cmpl_valid_i),
        .cmpl_tag_i   (cmpl_tag_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ########################################################################
    // Helpers
    // ########################################################################

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic report_mismatch(string name, int exp, int act);
        errors++;
        $display("MISMATCH %s: expected %0h, actual %0h (cycle %0d)", name, exp, act, cycle);
    endtask

    task automatic report_error(string msg);
        errors++;
        $display("ERROR: %s (cycle %0d)", msg, cycle);
    endtask

    // ########################################################################
    // Observation, after each rising edge
    // ########################################################################

    // Acknowledge rose, so the held instruction went in at this edge
    task automatic observe_acceptance();
        int inst;
        int tag;
        inst = accepted;
        if (dec_ack_o && !ack_prev) begin
            if (free_tags.size() == 0 || inst >= N_INSTR) begin
                report_error("decode accepted with every tag in flight");
            end else begin
                // Queue order, popped before any tag returned at this edge
                tag            = free_tags.pop_front();
                tag_owner[tag] = inst;
                acc_pc[inst]   = dec_pc_i;
                acc_mask[inst] = dec_mask_i;
                acc_dst[inst]  = dec_dst_i;
                // Lookup before the destination is claimed
                acc_dep0[inst] = reg_owner[dec_src0_i];
                acc_dep1[inst] = reg_owner[dec_src1_i];
                reg_owner[dec_dst_i] = inst;
            end
            if (accepted - acked >= WB_DEPTH) begin
                report_error("decode accepted with the wait buffer full");
            end
            accepted++;
        end
        ack_prev = dec_ack_o;
    endtask

    task automatic observe_completion();
        int inst;
        if (cmpl_valid_i) begin
            inst           = tag_owner[cmpl_tag_i];
            is_done[inst]  = 1'b1;
            // A newer writer keeps its register
            if (reg_owner[acc_dst[inst]] == inst) begin
                reg_owner[acc_dst[inst]] = -1;
            end
            tag_owner[cmpl_tag_i] = -1;
            free_tags.push_back(int'(cmpl_tag_i));
            completed++;
        end
    endtask

    // Payload and dependencies on a fresh issue request
    task automatic check_issue();
        int inst;
        inst      = tag_owner[iss_tag_o];
        iss_tag_q = int'(iss_tag_o);
        if (inst < 0) begin
            report_error("issue of a tag that is not in flight");
        end else begin
            if (is_issued[inst]) begin
                report_error("instruction issued a second time");
            end
            is_issued[inst] = 1'b1;
            if (iss_pc_o !== acc_pc[inst]) begin
                report_mismatch("issue pc", int'(acc_pc[inst]), int'(iss_pc_o));
            end
            if (iss_mask_o !== acc_mask[inst]) begin
                report_mismatch("issue mask", int'(acc_mask[inst]), int'(iss_mask_o));
            end
            if (iss_dst_o !== acc_dst[inst]) begin
                report_mismatch("issue dst", int'(acc_dst[inst]), int'(iss_dst_o));
            end
            if (acc_dep0[inst] >= 0 && !is_done[acc_dep0[inst]]) begin
                report_error("issue before the source 0 producer completed");
            end
            if (acc_dep1[inst] >= 0 && !is_done[acc_dep1[inst]]) begin
                report_error("issue before the source 1 producer completed");
            end
        end
    endtask

    // Execution unit side of the issue handshake
    task automatic observe_issue();
        if (iss_ack_i) begin
            // Acknowledge was sampled at this edge
            if (iss_req_o) begin
                report_error("issue request still high after its acknowledge");
            end
            acked++;
            pend_tag.push_back(iss_tag_q);
            pend_wait.push_back(int'(rand_bits(3)));
            iss_ack_i = 1'b0;
            iss_seen  = 1'b0;
        end else if (iss_req_o) begin
            if (!iss_seen) begin
                check_issue();
                iss_seen = 1'b1;
                ack_wait = int'(rand_bits(2));
            end
            if (ack_wait == 0) begin
                iss_ack_i = 1'b1;
            end else begin
                ack_wait--;
            end
        end
    endtask

    task automatic check_limits();
        if (accepted - completed > NUM_TAGS) begin
            report_error("more instructions in flight than there are tags");
        end
        if (accepted - acked > WB_DEPTH) begin
            report_error("more instructions waiting than wait-buffer entries");
        end
    endtask

    // ########################################################################
    // Stimulus, a small delay after each rising edge
    // ########################################################################

    // One completion strobe per cycle at most
    task automatic drive_completion();
        int pick;
        pick         = -1;
        cmpl_valid_i = 1'b0;
        for (int i = 0; i < pend_wait.size(); i++) begin
            if (pend_wait[i] > 0) begin
                pend_wait[i]--;
            end else if (pick < 0 && !hold_cmpl) begin
                pick = i;
            end
        end
        if (pick >= 0) begin
            cmpl_valid_i = 1'b1;
            cmpl_tag_i   = tag_t'(pend_tag[pick]);
            pend_tag.delete(pick);
            pend_wait.delete(pick);
        end
    endtask

    // Decoder side, registers 0 to 3 only so that dependencies are frequent
    task automatic drive_decoder();
        if (dec_req_i) begin
            if (dec_ack_o) begin
                dec_req_i = 1'b0;
            end
        end else if (!dec_ack_o && accepted < N_INSTR) begin
            if (gap > 0) begin
                gap--;
            end else begin
                dec_pc_i   = pc_t'(rand_bits(16));
                dec_mask_i = act_mask_t'(rand_bits(8));
                dec_dst_i  = reg_idx_t'(rand_bits(2));
                dec_src0_i = reg_idx_t'(rand_bits(2));
                dec_src1_i = reg_idx_t'(rand_bits(2));
                dec_req_i  = 1'b1;
                gap        = int'(rand_bits(2));
            end
        end
    endtask

    // ########################################################################
    // Main sequence
    // ########################################################################

    initial begin
        dec_req_i    = 1'b0;
        dec_pc_i     = '0;
        dec_mask_i   = '0;
        dec_dst_i    = '0;
        dec_src0_i   = '0;
        dec_src1_i   = '0;
        iss_ack_i    = 1'b0;
        cmpl_valid_i = 1'b0;
        cmpl_tag_i   = '0;
        lfsr_q       = 32'hea49c308;
        errors       = 0;
        cycle        = 0;
        accepted     = 0;
        acked        = 0;
        completed    = 0;
        hold_cmpl    = 1'b1;
        ack_prev     = 1'b0;
        gap          = 0;
        iss_seen     = 1'b0;
        iss_tag_q    = 0;
        ack_wait     = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            tag_owner[t] = -1;
            free_tags.push_back(t);
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            reg_owner[r] = -1;
        end
        for (int i = 0; i < N_INSTR; i++) begin
            is_issued[i] = 1'b0;
            is_done[i]   = 1'b0;
        end

        arst_n_i = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_i);
        #DRIVE_DLY;
        arst_n_i = 1'b1;
        if (dec_ack_o !== 1'b0) begin
            report_mismatch("reset dec_ack", 0, int'(dec_ack_o));
        end
        if (iss_req_o !== 1'b0) begin
            report_mismatch("reset iss_req", 0, int'(iss_req_o));
        end

        while (!(accepted == N_INSTR && completed == N_INSTR && !iss_ack_i)) begin
            @(posedge clk_i);
            #DRIVE_DLY;
            cycle++;
            // Decoder must be stuck by now, nothing has completed
            if (cycle == HOLD_CYCLES) begin
                if (!(dec_req_i && !dec_ack_o)) begin
                    report_error("no back-pressure while completions were withheld");
                end
                hold_cmpl = 1'b0;
            end
            observe_acceptance();
            observe_completion();
            observe_issue();
            check_limits();
            drive_completion();
            drive_decoder();
        end

        for (int i = 0; i < N_INSTR; i++) begin
            if (!is_issued[i]) begin
                report_error($sformatf("instruction %0d never issued", i));
            end
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // 40 cycles per instruction at most
    initial begin
        #(N_INSTR * 40 * CLK_PERIOD);
        errors++;
        $display("ERROR: timeout, %0d accepted and %0d completed of %0d",
                 accepted, completed, N_INSTR);
        $display("errors: %0d", errors);
        $display("tests failed");
        $finish;
    end

endmodule : dispatcher_tb

//--- list.f
+incdir+src
src/disp_pkg.sv
src/tag_queue.sv
src/reg_table.sv
src/wait_buffer.sv
src/dispatcher.sv
verif/dispatcher_props.sv
verif/dispatcher_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := dispatcher_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

# A crashed or stopped run counts as a failure as well
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "tests failed" >> $(LOG)
	cat $(LOG)
	! grep -q "tests failed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
